// ==== cpu_bus_pkg.sv ====
// ====================
// processor and memory bus word type
// word width and byte step
// ====================

package cpu_bus_pkg;

	// data and address words share one width
	localparam int WORD_W = 32;

	// bytes per word, also the step between the two words of a block
	localparam int WORD_BYTES = WORD_W / 8;

	typedef logic [WORD_W-1:0] word_t;

endpackage

// ==== cache_geom_pkg.sv ====
// ====================
// data cache geometry constants
// address decode union and line struct
// ====================

package cache_geom_pkg;

	localparam int NUM_WAYS = 2;
	localparam int NUM_SETS = 8;

	localparam int INDEX_W = $clog2(NUM_SETS);
	localparam int WORD_SEL_W = 1; // two words per block
	localparam int BYTE_OFF_W = $clog2(cpu_bus_pkg::WORD_BYTES);
	localparam int TAG_W = cpu_bus_pkg::WORD_W - INDEX_W - WORD_SEL_W - BYTE_OFF_W;

	typedef logic [INDEX_W-1:0] set_idx_t;
	typedef logic [TAG_W-1:0] cache_tag_t;
	typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

	typedef struct packed {
		cache_tag_t tag;
		set_idx_t index;
		logic word_sel; // high word of the block
		logic [BYTE_OFF_W-1:0] byte_off;
	} addr_fields_t;

	// same 32 bits, seen raw or split into fields
	typedef union packed {
		cpu_bus_pkg::word_t raw;
		addr_fields_t f;
	} dcache_addr_t;

	typedef struct packed {
		logic valid;
		logic dirty;
		cache_tag_t tag;
		cpu_bus_pkg::word_t word1;
		cpu_bus_pkg::word_t word0;
	} cache_line_t;

endpackage

// ==== dcache_array_if.sv ====
// ====================
// controller to line storage connection
// lookup, hit and write signals with modports
// ====================
`timescale 1ns/1ps

interface dcache_array_if;
	import cache_geom_pkg::*;

	// lookup side, combinational
	set_idx_t lookup_index;
	cache_tag_t lookup_tag;
	logic [NUM_WAYS-1:0] hit; // one bit per way
	cache_line_t [NUM_WAYS-1:0] rd_line;

	// write side, lands on the next edge
	logic wr_en;
	way_t wr_way;
	set_idx_t wr_index;
	cache_line_t wr_line; // whole entry

	modport ctrl (
		output lookup_index,
		output lookup_tag,
		output wr_en,
		output wr_way,
		output wr_index,
		output wr_line,
		input hit,
		input rd_line
	);

	modport store (
		input lookup_index,
		input lookup_tag,
		input wr_en,
		input wr_way,
		input wr_index,
		input wr_line,
		output hit,
		output rd_line
	);

endinterface

// ==== dcache_store.sv ====
// ====================
// line storage for both ways
// valid, dirty, tag and data plus way match
// ====================
`timescale 1ns/1ps

module dcache_store (
	input logic CLK,
	input logic nRST,
	dcache_array_if.store arr
);
	import cpu_bus_pkg::*;
	import cache_geom_pkg::*;

	// state bits per way and set
	logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;
	logic [NUM_WAYS-1:0][NUM_SETS-1:0] dirty_q;

	// payload
	cache_tag_t tag_q [NUM_WAYS][NUM_SETS];
	word_t word1_q [NUM_WAYS][NUM_SETS];
	word_t word0_q [NUM_WAYS][NUM_SETS];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (arr.wr_en) begin
			valid_q[arr.wr_way][arr.wr_index] <= arr.wr_line.valid;
			dirty_q[arr.wr_way][arr.wr_index] <= arr.wr_line.dirty;
		end
	end

	always_ff @(posedge CLK) begin
		if (arr.wr_en) begin
			tag_q[arr.wr_way][arr.wr_index] <= arr.wr_line.tag;
			word1_q[arr.wr_way][arr.wr_index] <= arr.wr_line.word1;
			word0_q[arr.wr_way][arr.wr_index] <= arr.wr_line.word0;
		end
	end

	// both ways of the lookup set are always presented
	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		assign arr.rd_line[w] = '{
			valid: valid_q[w][arr.lookup_index],
			dirty: dirty_q[w][arr.lookup_index],
			tag: tag_q[w][arr.lookup_index],
			word1: word1_q[w][arr.lookup_index],
			word0: word0_q[w][arr.lookup_index]
		};

		// stale tags of invalid lines never hit
		assign arr.hit[w] = valid_q[w][arr.lookup_index]
			&& (tag_q[w][arr.lookup_index] == arr.lookup_tag);
	end

endmodule

// ==== dcache_ctrl.sv ====
// ====================
// data cache controller FSM
// hit, allocate, write-back and flush
// ====================
`timescale 1ns/1ps

module dcache_ctrl #(
	parameter cpu_bus_pkg::word_t HIT_COUNT_ADDR = 32'h3100
) (
	input logic CLK,
	input logic nRST,
	input logic halt,
	input logic dmem_ren,
	input logic dmem_wen,
	input cpu_bus_pkg::word_t dmem_addr,
	input cpu_bus_pkg::word_t dmem_store,
	output logic dhit,
	output logic flushed,
	output cpu_bus_pkg::word_t dmem_load,
	output logic mem_ren,
	output logic mem_wen,
	output cpu_bus_pkg::word_t mem_addr,
	output cpu_bus_pkg::word_t mem_store,
	input logic mem_wait,
	input cpu_bus_pkg::word_t mem_load,
	dcache_array_if.ctrl arr
);
	import cpu_bus_pkg::*;
	import cache_geom_pkg::*;

	typedef enum logic [3:0] {
		IDLE,
		ALLOC1,
		ALLOC2,
		WB1,
		WB2,
		FLUSH_HI,
		FLUSH_LO,
		HIT_CNT,
		FLUSHED
	} state_t;

	state_t state, next_state;
	logic [NUM_SETS-1:0] repl_q, repl_d; // way to evict next, per set
	word_t hit_cnt_q, hit_cnt_d;
	logic [INDEX_W:0] flush_cnt_q, flush_cnt_d; // {set, way}

	dcache_addr_t req;
	dcache_addr_t fetch_addr;
	dcache_addr_t wb_addr;
	set_idx_t idx;
	set_idx_t flush_set;
	way_t hit_way, miss_way, victim, flush_way;
	cache_line_t hit_line, miss_line, vic_line, flush_line, fill_line;
	logic flushing;

	function automatic word_t pick_word(cache_line_t line, logic sel);
		return sel ? line.word1 : line.word0;
	endfunction

	function automatic cache_line_t put_word(cache_line_t line, logic sel, word_t data);
		cache_line_t res;
		res = line;
		if (sel) begin
			res.word1 = data;
		end else begin
			res.word0 = data;
		end
		return res;
	endfunction

	assign req.raw = dmem_addr;
	assign idx = req.f.index;
	assign flushing = (state == FLUSH_HI) || (state == FLUSH_LO);
	assign flush_way = flush_cnt_q[0];
	assign flush_set = flush_cnt_q[INDEX_W:1];
	assign flushed = (state == FLUSHED);

	assign arr.lookup_index = flushing ? flush_set : idx;
	assign arr.lookup_tag = req.f.tag;
	assign arr.wr_index = idx;

	assign hit_way = arr.hit[0] ? 1'b0 : 1'b1;
	assign victim = repl_q[idx];
	assign hit_line = arr.rd_line[hit_way];
	assign miss_line = arr.rd_line[miss_way];
	assign vic_line = arr.rd_line[victim];
	assign flush_line = arr.rd_line[flush_way];

	// first invalid, then first clean, else the replacement bit
	always_comb begin
		if (!arr.rd_line[0].valid) begin
			miss_way = 1'b0;
		end else if (!arr.rd_line[1].valid) begin
			miss_way = 1'b1;
		end else if (!arr.rd_line[0].dirty) begin
			miss_way = 1'b0;
		end else if (!arr.rd_line[1].dirty) begin
			miss_way = 1'b1;
		end else begin
			miss_way = repl_q[idx];
		end
	end

	always_comb begin
		fetch_addr.f.tag = req.f.tag;
		fetch_addr.f.index = idx;
		fetch_addr.f.word_sel = (state == ALLOC2) ? ~req.f.word_sel : req.f.word_sel;
		fetch_addr.f.byte_off = '0;

		wb_addr.f.byte_off = '0;
		if (flushing) begin
			wb_addr.f.tag = flush_line.tag;
			wb_addr.f.index = flush_set;
			wb_addr.f.word_sel = (state == FLUSH_HI); // high word goes out first
		end else begin
			wb_addr.f.tag = vic_line.tag;
			wb_addr.f.index = idx;
			wb_addr.f.word_sel = (state == WB1) ? req.f.word_sel : ~req.f.word_sel;
		end
	end

	// second beat merges the fetched word and any store data
	always_comb begin
		fill_line = put_word(vic_line, ~req.f.word_sel, mem_load);
		if (dmem_wen) begin
			fill_line = put_word(fill_line, req.f.word_sel, dmem_store);
			fill_line.dirty = 1'b1;
		end
	end

	always_comb begin
		next_state = state;
		repl_d = repl_q;
		hit_cnt_d = hit_cnt_q;
		flush_cnt_d = flush_cnt_q;
		dhit = 1'b0;
		dmem_load = pick_word(hit_line, req.f.word_sel);
		mem_ren = 1'b0;
		mem_wen = 1'b0;
		mem_addr = fetch_addr.raw;
		mem_store = '0;
		arr.wr_en = 1'b0;
		arr.wr_way = hit_way;
		arr.wr_line = put_word(hit_line, req.f.word_sel, dmem_store);
		arr.wr_line.dirty = 1'b1;

		case (state)
			IDLE: begin
				if (halt) begin
					next_state = FLUSH_HI;
				end else if (dmem_ren || dmem_wen) begin
					if (|arr.hit) begin
						dhit = 1'b1;
						hit_cnt_d = hit_cnt_q + 32'd1;
						repl_d[idx] = ~hit_way;
						arr.wr_en = dmem_wen; // write hit updates in place
					end else begin
						repl_d[idx] = miss_way;
						next_state = (miss_line.valid && miss_line.dirty) ? WB1 : ALLOC1;
					end
				end
			end

			ALLOC1: begin
				mem_ren = 1'b1;
				arr.wr_way = victim;
				arr.wr_line = put_word(vic_line, req.f.word_sel, mem_load);
				arr.wr_line.valid = 1'b1;
				arr.wr_line.dirty = 1'b0;
				arr.wr_line.tag = req.f.tag;
				if (!mem_wait) begin
					arr.wr_en = 1'b1;
					next_state = ALLOC2;
				end
			end

			ALLOC2: begin
				mem_ren = 1'b1;
				dmem_load = pick_word(vic_line, req.f.word_sel); // word from first beat
				arr.wr_way = victim;
				arr.wr_line = fill_line;
				if (!mem_wait) begin
					dhit = 1'b1;
					arr.wr_en = 1'b1;
					repl_d[idx] = ~victim;
					next_state = IDLE;
				end
			end

			WB1, WB2: begin
				mem_wen = 1'b1;
				mem_addr = wb_addr.raw;
				mem_store = pick_word(vic_line, wb_addr.f.word_sel);
				if (!mem_wait) begin
					next_state = (state == WB1) ? WB2 : ALLOC1;
				end
			end

			FLUSH_HI, FLUSH_LO: begin
				mem_addr = wb_addr.raw;
				mem_store = pick_word(flush_line, wb_addr.f.word_sel);
				if (state == FLUSH_HI && !flush_line.dirty) begin
					// clean entry, skip ahead
					if (flush_cnt_q == '1) begin
						next_state = HIT_CNT;
					end else begin
						flush_cnt_d = flush_cnt_q + 1'b1;
					end
				end else begin
					mem_wen = 1'b1;
					if (!mem_wait) begin
						if (state == FLUSH_HI) begin
							next_state = FLUSH_LO;
						end else if (flush_cnt_q == '1) begin
							next_state = HIT_CNT;
						end else begin
							flush_cnt_d = flush_cnt_q + 1'b1;
							next_state = FLUSH_HI;
						end
					end
				end
			end

			HIT_CNT: begin
				mem_wen = 1'b1;
				mem_addr = HIT_COUNT_ADDR;
				mem_store = hit_cnt_q;
				if (!mem_wait) begin
					next_state = FLUSHED;
				end
			end

			FLUSHED: begin
				next_state = FLUSHED; // held until reset
			end

			default: begin
				next_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			repl_q <= '0;
			hit_cnt_q <= '0;
			flush_cnt_q <= '0;
		end else begin
			state <= next_state;
			repl_q <= repl_d;
			hit_cnt_q <= hit_cnt_d;
			flush_cnt_q <= flush_cnt_d;
		end
	end

endmodule

// ==== dcache.sv ====
// ====================
// data cache top level
// storage and controller instances
// ====================
`timescale 1ns/1ps

module dcache #(
	parameter cpu_bus_pkg::word_t HIT_COUNT_ADDR = 32'h3100
) (
	input logic CLK,
	input logic nRST,
	input logic halt,
	input logic dmem_ren,
	input logic dmem_wen,
	input cpu_bus_pkg::word_t dmem_addr,
	input cpu_bus_pkg::word_t dmem_store,
	output logic dhit,
	output logic flushed,
	output cpu_bus_pkg::word_t dmem_load,
	output logic mem_ren,
	output logic mem_wen,
	output cpu_bus_pkg::word_t mem_addr,
	output cpu_bus_pkg::word_t mem_store,
	input logic mem_wait,
	input cpu_bus_pkg::word_t mem_load
);

	dcache_array_if arr_if ();

	dcache_store store_inst (
		.CLK (CLK),
		.nRST (nRST),
		.arr (arr_if.store)
	);

	dcache_ctrl #(
		.HIT_COUNT_ADDR (HIT_COUNT_ADDR)
	) ctrl_inst (
		.CLK (CLK),
		.nRST (nRST),
		.halt (halt),
		.dmem_ren (dmem_ren),
		.dmem_wen (dmem_wen),
		.dmem_addr (dmem_addr),
		.dmem_store (dmem_store),
		.dhit (dhit),
		.flushed (flushed),
		.dmem_load (dmem_load),
		.mem_ren (mem_ren),
		.mem_wen (mem_wen),
		.mem_addr (mem_addr),
		.mem_store (mem_store),
		.mem_wait (mem_wait),
		.mem_load (mem_load),
		.arr (arr_if.ctrl)
	);

endmodule

// ==== tb_mem_model.sv ====
// ====================
// word memory model with random wait states
// ====================
`timescale 1ns/1ps

module tb_mem_model (
	input logic CLK,
	input logic nRST,
	input logic mem_ren,
	input logic mem_wen,
	input cpu_bus_pkg::word_t mem_addr,
	input cpu_bus_pkg::word_t mem_store,
	output logic mem_wait,
	output cpu_bus_pkg::word_t mem_load
);
	import cpu_bus_pkg::*;

	word_t mem [word_t]; // only written words are held
	logic [15:0] lfsr;
	int wait_run;
	int wr_count;

	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// untouched words read back as the inverted address
	function automatic word_t peek(word_t a);
		return mem.exists(a) ? mem[a] : ~a;
	endfunction

	always @(mem_addr, mem_ren, wr_count) begin
		mem_load = mem_ren ? peek(mem_addr) : '0;
	end

	always @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lfsr <= 16'd94;
			mem_wait <= 1'b0;
			wait_run <= 0;
			wr_count <= 0;
		end else begin
			if (mem_wen && !mem_wait) begin
				mem[mem_addr] = mem_store;
				wr_count <= wr_count + 1;
			end
			lfsr <= lfsr_next(lfsr); // one bit per cycle
			if (lfsr[0] && wait_run < 7) begin
				mem_wait <= 1'b1;
				wait_run <= wait_run + 1;
			end else begin
				mem_wait <= 1'b0; // at most 7 stalls in a row
				wait_run <= 0;
			end
		end
	end

endmodule

// ==== tb_dcache.sv ====
// ====================
// data cache testbench
// directed tests, compare tasks and watchdog
// ====================
`timescale 1ns/1ps

module tb_dcache;
	import cpu_bus_pkg::*;
	import cache_geom_pkg::*;

	localparam word_t HIT_ADDR = 32'h3100;
	localparam int CLK_NS = 40;
	localparam int OP_CYCLES = 4 * 8 + 4; // 4 beats of up to 8 cycles

	logic CLK, nRST, halt, dmem_ren, dmem_wen;
	logic dhit, flushed, mem_ren, mem_wen, mem_wait;
	word_t dmem_addr, dmem_store, dmem_load;
	word_t mem_addr, mem_store, mem_load;

	int errors = 0;
	int first_err = 0;
	int tests_run = 0;
	int tests_bad = 0;
	int exp_hits = 0;
	string test_name = "reset";
	time deadline = 1000;
	logic [15:0] rng = 16'd94;

	// shadow memory and reference tag state
	word_t shadow [word_t];
	logic [NUM_WAYS-1:0] m_val [NUM_SETS] = '{default: '0};
	logic [NUM_WAYS-1:0] m_dirty [NUM_SETS] = '{default: '0};
	way_t m_repl [NUM_SETS] = '{default: '0};
	cache_tag_t m_tag [NUM_SETS][NUM_WAYS];

	dcache #(.HIT_COUNT_ADDR(HIT_ADDR)) dcache_inst (.*);
	tb_mem_model mem_inst (.*);

	initial begin
		CLK = 1'b0;
		forever #(CLK_NS / 2) CLK = ~CLK;
	end

	initial begin
		while ($time <= deadline) begin
			@(negedge CLK);
		end
		$display("timeout in %s, the cache stopped answering", test_name);
		$display("Test failed");
		$finish;
	end

	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic word_t rand_bits(int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], rng[0]};
			rng = lfsr_next(rng);
		end
		return v;
	endfunction

	function automatic word_t expected_word(word_t a);
		return shadow.exists(a) ? shadow[a] : ~a;
	endfunction

	// applies one access to the tag state and returns the predicted hit
	function automatic logic model_access(word_t addr, logic wr);
		dcache_addr_t a;
		set_idx_t s;
		way_t w;
		logic hit;
		a.raw = addr;
		s = a.f.index;
		hit = 1'b0;
		w = '0;
		for (int i = 0; i < NUM_WAYS; i++) begin
			if (m_val[s][i] && m_tag[s][i] == a.f.tag) begin
				hit = 1'b1;
				w = way_t'(i);
			end
		end
		if (!hit) begin
			if (m_val[s] != '1) begin
				w = m_val[s][0]; // first invalid
			end else if (m_dirty[s] != '1) begin
				w = m_dirty[s][0]; // first clean
			end else begin
				w = m_repl[s];
			end
			m_val[s][w] = 1'b1;
			m_dirty[s][w] = 1'b0;
			m_tag[s][w] = a.f.tag;
		end
		m_repl[s] = ~w;
		m_dirty[s][w] = m_dirty[s][w] | wr;
		return hit;
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic start_test(input string name, input int ops);
		test_name = name;
		first_err = errors;
		deadline = $time + ops * OP_CYCLES * CLK_NS;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors != first_err) begin
			tests_bad++;
		end
		$display("%s: %0d errors", test_name, errors - first_err);
	endtask

	task automatic drive_access(input word_t addr, input logic wr, input word_t data,
		output word_t rd);
		logic exp_hit;
		exp_hit = model_access(addr, wr);
		if (exp_hit) begin
			exp_hits++;
		end
		@(posedge CLK);
		dmem_addr <= addr;
		dmem_store <= data;
		dmem_ren <= !wr;
		dmem_wen <= wr;
		@(negedge CLK);
		check_bit("dhit", dhit, exp_hit); // hits answer in the request cycle
		if (exp_hit) begin
			check_bit("mem_ren", mem_ren, 1'b0);
			check_bit("mem_wen", mem_wen, 1'b0);
		end
		while (!dhit) begin
			@(negedge CLK);
		end
		rd = dmem_load;
		@(posedge CLK);
		dmem_ren <= 1'b0;
		dmem_wen <= 1'b0;
	endtask

	task automatic read_check(input word_t addr);
		word_t rd;
		drive_access(addr, 1'b0, '0, rd);
		check_word($sformatf("dmem_load @%h", addr), rd, expected_word(addr));
	endtask

	task automatic write_word(input word_t addr, input word_t data);
		word_t rd;
		drive_access(addr, 1'b1, data, rd);
		shadow[addr] = data;
	endtask

	task automatic reset_outputs();
		start_test("reset values", 1);
		@(negedge CLK);
		check_bit("dhit", dhit, 1'b0);
		check_bit("mem_ren", mem_ren, 1'b0);
		check_bit("mem_wen", mem_wen, 1'b0);
		check_bit("flushed", flushed, 1'b0);
		end_test();
	endtask

	task automatic read_miss_then_hit();
		start_test("read miss then hits", 3);
		read_check(32'h1008);
		read_check(32'h1008);
		read_check(32'h100C); // other word of the block
		end_test();
	endtask

	task automatic write_hit_in_place();
		start_test("write hit", 2);
		write_word(32'h100C, rand_bits(32));
		read_check(32'h100C);
		check_word("mem[0000100c]", mem_inst.peek(32'h100C), ~word_t'(32'h100C));
		end_test();
	endtask

	task automatic dirty_eviction();
		start_test("dirty eviction", 4);
		write_word(32'h2028, rand_bits(32)); // three tags in set 5
		write_word(32'h2428, rand_bits(32));
		write_word(32'h2828, rand_bits(32));
		check_word("mem[00002028]", mem_inst.peek(32'h2028), shadow[32'h2028]);
		read_check(32'h2028);
		end_test();
	endtask

	task automatic random_traffic(input int n);
		word_t a;
		start_test("random access", n);
		for (int i = 0; i < n; i++) begin
			a = 32'h400 | (rand_bits(6) << 2); // 4 tags over all sets
			if (rand_bits(1)) begin
				write_word(a, rand_bits(32));
			end else begin
				read_check(a);
			end
		end
		end_test();
	endtask

	task automatic flush_on_halt();
		start_test("flush on halt", 17);
		@(posedge CLK);
		halt <= 1'b1;
		while (!flushed) begin
			@(negedge CLK);
		end
		foreach (shadow[a]) begin
			check_word($sformatf("mem[%h]", a), mem_inst.peek(a), shadow[a]);
		end
		check_word("mem[00003100]", mem_inst.peek(HIT_ADDR), word_t'(exp_hits));
		repeat (20) begin
			@(negedge CLK);
			check_bit("flushed", flushed, 1'b1);
			check_bit("mem_ren", mem_ren, 1'b0);
			check_bit("mem_wen", mem_wen, 1'b0);
		end
		end_test();
	endtask

	initial begin
		nRST = 1'b0;
		halt = 1'b0;
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
		dmem_addr = '0;
		dmem_store = '0;
		repeat (5) @(posedge CLK);
		nRST <= 1'b1;
		reset_outputs();
		read_miss_then_hit();
		write_hit_in_place();
		dirty_eviction();
		random_traffic(40);
		flush_on_halt();
		$display("%0d tests, %0d with errors, %0d errors in all", tests_run, tests_bad, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
cpu_bus_pkg.sv
cache_geom_pkg.sv
dcache_array_if.sv
dcache_store.sv
dcache_ctrl.sv
dcache.sv
tb_mem_model.sv
tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - cpu_bus_pkg.sv
  - cache_geom_pkg.sv
  - dcache_array_if.sv
  - dcache_store.sv
  - dcache_ctrl.sv
  - dcache.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_dcache.sv
